// ==== bp_if.sv ====
`timescale 1ns/1ps

// Same-cycle lookup path between the controller, the history and the uBTB
interface bp_lookup_if
    import frontend_cfg_pkg::*, bp_types_pkg::*;
();
    logic [XLEN-1:0] lookup_pc;
    logic [BR_HISTORY_LENGTH-1:0] gbh;
    ubtb_info_t info;

    modport ctrl (output lookup_pc, input info);
    modport hist (output gbh, input info); // Hit qualifies the speculative shift
    modport pred (input lookup_pc, input gbh, output info);
endinterface

// Resolved branch training from the back end
interface bp_update_if
    import frontend_cfg_pkg::*, bp_types_pkg::*;
();
    logic update;
    logic [XLEN-1:0] update_pc;
    logic [BR_HISTORY_LENGTH-1:0] arch_gbh;
    ubtb_info_t update_info;

    modport hist (
        input update,
        input update_info,
        output arch_gbh
    );
    modport train (
        input update,
        input update_pc,
        input arch_gbh,
        input update_info
    );
endinterface

// ==== bp_types_pkg.sv ====
package bp_types_pkg;

    import frontend_cfg_pkg::*;

    // Prediction for one fetch block and also the training record
    typedef struct packed {
        logic hit;
        logic taken;
        logic [XLEN-1:0] fallthru_addr;
        logic [XLEN-1:0] target_addr;
        logic [XLEN-1:0] next_addr;
    } ubtb_info_t;

    // Fetch controller states
    typedef enum logic [1:0] {
        ST_BOOT,
        ST_FETCH,
        ST_HOLD
    } fetch_state_e;

    // Two-bit saturating counter step toward the resolved direction
    function automatic logic [1:0] counter_update(
        input logic [1:0] cnt,
        input logic taken
    );
        logic [1:0] res;
        res = cnt;
        if (taken) begin
            if (cnt != 2'd3) begin
                res = cnt + 2'd1;
            end
        end else begin
            if (cnt != 2'd0) begin
                res = cnt - 2'd1;
            end
        end
        return res;
    endfunction

endpackage

// ==== branch_history.sv ====
`timescale 1ns/1ps

module branch_history
    import frontend_cfg_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic i_fetch_fire,
    input logic i_pred_taken,
    input logic i_restore,
    bp_lookup_if.hist lookup,
    bp_update_if.hist upd
);
    logic [BR_HISTORY_LENGTH-1:0] spec_gbh_q;
    logic [BR_HISTORY_LENGTH-1:0] arch_gbh_q;
    logic [BR_HISTORY_LENGTH-1:0] arch_gbh_next;

    // Architectural copy moves only on resolved branches
    assign arch_gbh_next = upd.update ?
                           {arch_gbh_q[BR_HISTORY_LENGTH-2:0], upd.update_info.taken} :
                           arch_gbh_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_gbh_q <= '0;
            arch_gbh_q <= '0;
        end else begin
            arch_gbh_q <= arch_gbh_next;
            if (i_restore) begin
                spec_gbh_q <= arch_gbh_next; // Includes the update of this same cycle
            end else if (i_fetch_fire && lookup.info.hit) begin
                spec_gbh_q <= {spec_gbh_q[BR_HISTORY_LENGTH-2:0], i_pred_taken};
            end
        end
    end

    assign lookup.gbh = spec_gbh_q;
    assign upd.arch_gbh = arch_gbh_q;

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl
    import frontend_cfg_pkg::*, bp_types_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_VECTOR = 'h1000
) (
    input logic clk,
    input logic rst,
    input logic i_stall,
    input logic i_redirect,
    input logic [XLEN-1:0] i_redirect_pc,
    bp_lookup_if.ctrl lookup,
    output logic o_fetch_valid,
    output logic o_fetch_fire,
    output logic o_restore
);
    fetch_state_e state_q;
    fetch_state_e state_next;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    always_comb begin
        state_next = state_q;
        pc_next = pc_q;
        if (i_redirect) begin
            state_next = ST_FETCH; // Redirect overrides stall and boot
            pc_next = i_redirect_pc;
        end else begin
            case (state_q)
                ST_BOOT: begin
                    state_next = ST_FETCH;
                end
                ST_FETCH: begin
                    if (i_stall) begin
                        state_next = ST_HOLD;
                    end else begin
                        pc_next = lookup.info.next_addr;
                    end
                end
                ST_HOLD: begin
                    if (!i_stall) begin
                        state_next = ST_FETCH;
                    end
                end
                default: begin
                    state_next = ST_BOOT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_BOOT;
            pc_q <= RESET_VECTOR;
        end else begin
            state_q <= state_next;
            pc_q <= pc_next;
        end
    end

    assign lookup.lookup_pc = pc_q;
    assign o_fetch_valid = (state_q == ST_FETCH);
    assign o_fetch_fire = (state_q == ST_FETCH) && !i_stall; // Block accepted downstream
    assign o_restore = i_redirect;

    // Predicted and redirected addresses must stay halfword aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        o_fetch_valid |-> !pc_q[0])
        else $error("fetch_ctrl: odd fetch pc %h", pc_q);

endmodule

// ==== frontend_bp.f ====
frontend_cfg_pkg.sv
bp_types_pkg.sv
bp_if.sv
ubtb.sv
branch_history.sv
fetch_ctrl.sv
frontend_bp_top.sv
tb_clock_gen.sv
tb_frontend_bp.sv

// ==== frontend_bp_top.sv ====
`timescale 1ns/1ps

module frontend_bp_top
    import frontend_cfg_pkg::*;
#(
    parameter int DEPTH = 32,
    parameter logic [XLEN-1:0] RESET_VECTOR = 'h1000
) (
    input logic clk,
    input logic rst,
    input logic i_stall,
    input logic i_redirect,
    input logic [XLEN-1:0] i_redirect_pc,
    input logic i_update,
    input logic [XLEN-1:0] i_update_pc,
    input logic i_update_taken,
    input logic [XLEN-1:0] i_update_fallthru,
    input logic [XLEN-1:0] i_update_target,
    output logic o_fetch_valid,
    output logic [XLEN-1:0] o_fetch_pc,
    output logic o_pred_hit,
    output logic o_pred_taken,
    output logic [XLEN-1:0] o_next_pc
);
    bp_lookup_if lookup_bus ();
    bp_update_if upd_bus ();

    logic fetch_fire;
    logic restore;

    assign upd_bus.update = i_update;
    assign upd_bus.update_pc = i_update_pc;
    assign upd_bus.update_info = '{
        hit: 1'b1,
        taken: i_update_taken,
        fallthru_addr: i_update_fallthru,
        target_addr: i_update_target,
        next_addr: i_update_taken ? i_update_target : i_update_fallthru
    };

    fetch_ctrl #(.RESET_VECTOR(RESET_VECTOR)) u_fetch_ctrl (
        .clk(clk),
        .rst(rst),
        .i_stall(i_stall),
        .i_redirect(i_redirect),
        .i_redirect_pc(i_redirect_pc),
        .lookup(lookup_bus.ctrl),
        .o_fetch_valid(o_fetch_valid),
        .o_fetch_fire(fetch_fire),
        .o_restore(restore)
    );

    branch_history u_branch_history (
        .clk(clk),
        .rst(rst),
        .i_fetch_fire(fetch_fire),
        .i_pred_taken(lookup_bus.info.taken),
        .i_restore(restore),
        .lookup(lookup_bus.hist),
        .upd(upd_bus.hist)
    );

    ubtb #(.DEPTH(DEPTH)) u_ubtb (
        .clk(clk),
        .rst(rst),
        .lookup(lookup_bus.pred),
        .upd(upd_bus.train)
    );

    assign o_fetch_pc = lookup_bus.lookup_pc;
    assign o_pred_hit = lookup_bus.info.hit;
    assign o_pred_taken = lookup_bus.info.taken;
    assign o_next_pc = lookup_bus.info.next_addr;

endmodule

// ==== frontend_bp_vectors.txt ====
# end stall redir redir_pc upd upd_pc taken fallthru target | valid pc hit taken next
# All hex; end is the test number on the last line of a test, else 0
0 0 0 00000000 0 00000000 0 00000000 00000000 0 00001000 0 0 00001010
0 0 0 00000000 0 00000000 0 00000000 00000000 1 00001000 0 0 00001010
0 0 0 00000000 0 00000000 0 00000000 00000000 1 00001010 0 0 00001020
1 0 0 00000000 0 00000000 0 00000000 00000000 1 00001020 0 0 00001030
0 0 1 00002000 0 00000000 0 00000000 00000000 1 00001030 0 0 00001040
0 1 0 00000000 1 00002000 1 00002008 00002400 1 00002000 0 0 00002010
0 0 0 00000000 0 00000000 0 00000000 00000000 0 00002000 1 1 00002400
0 0 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 1 00002400
2 0 0 00000000 0 00000000 0 00000000 00000000 1 00002400 0 0 00002410
0 1 0 00000000 1 00002000 0 00002008 00002400 1 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 0 00000000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 1 1 00002000 1 00002000 0 00002008 00002400 0 00002410 0 0 00002420
0 0 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 0 00002008
0 1 0 00000000 1 00002000 1 00002008 00002400 1 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 0 00000000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
0 1 1 00002000 1 00002000 1 00002008 00002400 0 00002008 0 0 00002018
3 0 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 1 00002400
0 0 1 00002420 0 00000000 0 00000000 00000000 1 00002400 0 0 00002410
4 0 0 00000000 0 00000000 0 00000000 00000000 1 00002420 0 0 00002430
0 0 1 00002000 0 00000000 0 00000000 00000000 1 00002430 0 0 00002440
0 1 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 1 00002400
0 1 0 00000000 0 00000000 0 00000000 00000000 0 00002000 1 1 00002400
0 0 0 00000000 0 00000000 0 00000000 00000000 0 00002000 1 1 00002400
5 0 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 1 00002400
0 1 0 00000000 0 00000000 0 00000000 00000000 1 00002400 0 0 00002410
0 1 1 00002000 1 00002000 0 00002008 00002400 0 00002400 0 0 00002410
6 0 0 00000000 0 00000000 0 00000000 00000000 1 00002000 1 0 00002008

// ==== frontend_cfg_pkg.sv ====
package frontend_cfg_pkg;

    // Address and history widths of the fetch front end
    localparam int XLEN = 32;
    localparam int BR_HISTORY_LENGTH = 16;

    // uBTB entry field widths
    localparam int TAG_WIDTH = 8;
    localparam int TARGET_WIDTH = 11; // Target keeps bits [TARGET_WIDTH:1] and bit 0 is always zero

    // One fetch block covers this many bytes
    localparam int FTB_PREDICT_WIDTH = 16;
    localparam int FALLTHRU_OFF_WIDTH = $clog2(FTB_PREDICT_WIDTH);

    // Weakly not-taken starting point of every counter
    localparam logic [1:0] CNT_INIT = 2'd1;

    // Counter value from which a hit is predicted taken
    localparam logic [1:0] CNT_TAKEN_MIN = 2'd2;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime HALF_PERIOD = 2.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk; // 4 ns period

endmodule

// ==== tb_frontend_bp.sv ====
`timescale 1ns/1ps

module tb_frontend_bp;

    localparam int MAX_VEC = 128;
    localparam int RESET_CYCLES = 4;

    logic clk;
    logic rst;
    logic i_stall;
    logic i_redirect;
    logic [31:0] i_redirect_pc;
    logic i_update;
    logic [31:0] i_update_pc;
    logic i_update_taken;
    logic [31:0] i_update_fallthru;
    logic [31:0] i_update_target;
    logic o_fetch_valid;
    logic [31:0] o_fetch_pc;
    logic o_pred_hit;
    logic o_pred_taken;
    logic [31:0] o_next_pc;

    // One entry per vector line
    logic [31:0] v_end [MAX_VEC];
    logic [31:0] v_stall [MAX_VEC];
    logic [31:0] v_redir [MAX_VEC];
    logic [31:0] v_redir_pc [MAX_VEC];
    logic [31:0] v_upd [MAX_VEC];
    logic [31:0] v_upd_pc [MAX_VEC];
    logic [31:0] v_taken [MAX_VEC];
    logic [31:0] v_fall [MAX_VEC];
    logic [31:0] v_tgt [MAX_VEC];
    logic [31:0] e_valid [MAX_VEC];
    logic [31:0] e_pc [MAX_VEC];
    logic [31:0] e_hit [MAX_VEC];
    logic [31:0] e_taken [MAX_VEC];
    logic [31:0] e_next [MAX_VEC];

    int nvec;
    int cycle_limit;
    int cycles;
    int total_errs;
    int test_errs;
    int tests_passed;
    int tests_failed;

    tb_clock_gen u_clk (
        .clk(clk)
    );

    frontend_bp_top #(
        .DEPTH(32),
        .RESET_VECTOR(32'h1000)
    ) uut (
        .clk(clk),
        .rst(rst),
        .i_stall(i_stall),
        .i_redirect(i_redirect),
        .i_redirect_pc(i_redirect_pc),
        .i_update(i_update),
        .i_update_pc(i_update_pc),
        .i_update_taken(i_update_taken),
        .i_update_fallthru(i_update_fallthru),
        .i_update_target(i_update_target),
        .o_fetch_valid(o_fetch_valid),
        .o_fetch_pc(o_fetch_pc),
        .o_pred_hit(o_pred_hit),
        .o_pred_taken(o_pred_taken),
        .o_next_pc(o_next_pc)
    );

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        fd = $fopen("frontend_bp_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vectors file");
            total_errs++;
        end else begin
            while (!$feof(fd) && nvec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue; // Comment or blank line
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v_end[nvec], v_stall[nvec], v_redir[nvec], v_redir_pc[nvec],
                            v_upd[nvec], v_upd_pc[nvec], v_taken[nvec], v_fall[nvec],
                            v_tgt[nvec], e_valid[nvec], e_pc[nvec], e_hit[nvec],
                            e_taken[nvec], e_next[nvec]);
                if (n == 14) begin
                    nvec++;
                end else begin
                    $display("Malformed vector line: %s", line);
                    total_errs++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h got %h at cycle %0d", name, exp, act, cycles);
            test_errs++;
            total_errs++;
        end
    endtask

    task automatic apply_vector(input int i);
        i_stall = v_stall[i][0];
        i_redirect = v_redir[i][0];
        i_redirect_pc = v_redir_pc[i];
        i_update = v_upd[i][0];
        i_update_pc = v_upd_pc[i];
        i_update_taken = v_taken[i][0];
        i_update_fallthru = v_fall[i];
        i_update_target = v_tgt[i];
    endtask

    // Run ends here if the vectors never finish
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles without finishing the vectors", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        i_stall = 1'b0;
        i_redirect = 1'b0;
        i_redirect_pc = '0;
        i_update = 1'b0;
        i_update_pc = '0;
        i_update_taken = 1'b0;
        i_update_fallthru = '0;
        i_update_target = '0;
        nvec = 0;
        cycles = 0;
        cycle_limit = 0;
        total_errs = 0;
        test_errs = 0;
        tests_passed = 0;
        tests_failed = 0;

        load_vectors();
        cycle_limit = nvec + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < nvec; i++) begin
            if (i != 0) begin
                @(negedge clk);
            end
            apply_vector(i);
            #1; // Just ahead of the next rising edge
            compare("o_fetch_valid", e_valid[i], {31'b0, o_fetch_valid});
            compare("o_fetch_pc", e_pc[i], o_fetch_pc);
            compare("o_pred_hit", e_hit[i], {31'b0, o_pred_hit});
            compare("o_pred_taken", e_taken[i], {31'b0, o_pred_taken});
            compare("o_next_pc", e_next[i], o_next_pc);
            if (v_end[i] != 0) begin
                if (test_errs == 0) begin
                    $display("Test %0d PASS", v_end[i]);
                    tests_passed++;
                end else begin
                    $display("Test %0d FAIL with %0d mismatches", v_end[i], test_errs);
                    tests_failed++;
                end
                test_errs = 0;
            end
        end

        if (nvec == 0) begin
            $display("No vectors were loaded");
            total_errs++;
        end

        $display("Tests passed %0d, failed %0d, mismatches %0d, vectors %0d",
                 tests_passed, tests_failed, total_errs, nvec);
        if (total_errs == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== ubtb.sv ====
`timescale 1ns/1ps

module ubtb
    import frontend_cfg_pkg::*, bp_types_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input logic clk,
    input logic rst,
    bp_lookup_if.pred lookup,
    bp_update_if.train upd
);
    localparam int IDX_W = $clog2(DEPTH);
    localparam int PHT_DEPTH = DEPTH * 2;
    localparam int PHT_W = $clog2(PHT_DEPTH);

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [FALLTHRU_OFF_WIDTH-1:0] fallthru_off; // Zero encodes a full block
        logic [TARGET_WIDTH-1:0] target;
    } ubtb_entry_t;

    logic btb_vld [DEPTH];
    ubtb_entry_t btb_data [DEPTH];
    logic [1:0] pht [PHT_DEPTH];

    function automatic logic [IDX_W-1:0] btb_index(input logic [XLEN-1:0] pc);
        return pc[IDX_W:1] ^ pc[2*IDX_W:IDX_W+1];
    endfunction

    function automatic logic [PHT_W-1:0] pht_index(
        input logic [XLEN-1:0] pc,
        input logic [BR_HISTORY_LENGTH-1:0] hist
    );
        return pc[PHT_W:1] ^ hist[PHT_W-1:0];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] tag_of(input logic [XLEN-1:0] pc);
        return pc[TAG_WIDTH:1] ^ pc[2*TAG_WIDTH:TAG_WIDTH+1];
    endfunction

    logic [IDX_W-1:0] rd_idx;
    logic [PHT_W-1:0] rd_pht_idx;
    ubtb_entry_t rd_entry;
    logic [1:0] rd_cnt;
    logic [FALLTHRU_OFF_WIDTH:0] rd_span;
    logic hit;
    logic taken;
    logic [XLEN-1:0] fallthru_addr;
    logic [XLEN-1:0] target_addr;
    logic [XLEN-1:0] seq_addr;
    logic [XLEN-1:0] next_addr;

    assign rd_idx = btb_index(lookup.lookup_pc);
    assign rd_pht_idx = pht_index(lookup.lookup_pc, lookup.gbh);
    assign rd_entry = btb_data[rd_idx];
    assign rd_cnt = pht[rd_pht_idx];

    assign hit = btb_vld[rd_idx] && (rd_entry.tag == tag_of(lookup.lookup_pc));
    assign taken = hit && (rd_cnt >= CNT_TAKEN_MIN);

    assign rd_span = (rd_entry.fallthru_off == '0) ?
                     (FALLTHRU_OFF_WIDTH+1)'(FTB_PREDICT_WIDTH) : {1'b0, rd_entry.fallthru_off};
    assign fallthru_addr = lookup.lookup_pc + XLEN'(rd_span);
    assign target_addr = {lookup.lookup_pc[XLEN-1:TARGET_WIDTH+1], rd_entry.target, 1'b0};
    assign seq_addr = lookup.lookup_pc + XLEN'(FTB_PREDICT_WIDTH); // Miss falls to the next block
    assign next_addr = taken ? target_addr : (hit ? fallthru_addr : seq_addr);

    assign lookup.info = '{
        hit: hit,
        taken: taken,
        fallthru_addr: fallthru_addr,
        target_addr: target_addr,
        next_addr: next_addr
    };

    logic [IDX_W-1:0] wr_idx;
    logic [PHT_W-1:0] wr_pht_idx;
    logic [XLEN-1:0] wr_span;
    ubtb_entry_t wr_entry;

    assign wr_idx = btb_index(upd.update_pc);
    assign wr_pht_idx = pht_index(upd.update_pc, upd.arch_gbh); // Trained on the committed history
    assign wr_span = upd.update_info.fallthru_addr - upd.update_pc;
    assign wr_entry = '{
        tag: tag_of(upd.update_pc),
        fallthru_off: wr_span[FALLTHRU_OFF_WIDTH-1:0],
        target: upd.update_info.target_addr[TARGET_WIDTH:1]
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                btb_vld[i] <= 1'b0;
            end
        end else if (upd.update) begin
            btb_vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.update) begin
            btb_data[wr_idx] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht[i] <= CNT_INIT;
            end
        end else if (upd.update) begin
            pht[wr_pht_idx] <= counter_update(pht[wr_pht_idx], upd.update_info.taken);
        end
    end

    // A trained block must end inside one fetch block past its start
    a_update_span: assert property (@(posedge clk) disable iff (rst)
        upd.update |-> (wr_span inside {[1:FTB_PREDICT_WIDTH]}))
        else $error("ubtb: fallthru offset %0h out of range", wr_span);

endmodule
